// File: Bender.yml
package:
  name: proc

sources:
  - design/proc_pkg.sv
  - design/fetch.sv
  - design/decode.sv
  - design/execute.sv
  - design/hazard_unit.sv
  - design/mem_arbiter.sv
  - design/unified_memory.sv
  - design/proc.sv
  - target: test
    files:
      - test/tb_proc.sv

// File: design/decode.sv
// ID stage of the core, decodes controls and immediates, reads the register file, fills ID/EX
`timescale 1ns/1ns
`default_nettype none

module decode (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               flush,
    input  proc_pkg::word_t    id_pc, id_instr,
    input  logic               wb_en,
    input  proc_pkg::reg_idx_t wb_rd,
    input  proc_pkg::word_t    wb_data,
    output proc_pkg::word_t    ex_pc, ex_rs1_data, ex_rs2_data, ex_imm,
    output proc_pkg::reg_idx_t ex_rs1, ex_rs2, ex_rd,
    output proc_pkg::alu_op_e  ex_alu_op,
    output logic               ex_use_imm, ex_reg_write, ex_mem_read, ex_mem_write,
    output logic               ex_branch, ex_branch_ne, ex_jal, ex_halt, ex_illegal
);
    import proc_pkg::*;

    word_t      instr, imm, rs1_data, rs2_data;
    word_t      regs [32];
    opcode_e    opcode;
    logic [2:0] funct3;
    reg_idx_t   rs1, rs2;
    alu_op_e    alu_op;
    logic       use_imm, reg_write, mem_read, mem_write, branch, jal, halt, illegal;

    // Flushed slot decodes as a NOP
    assign instr  = flush ? NOP_INSTR : id_instr;
    assign opcode = opcode_e'(instr[6:0]);
    assign funct3 = instr[14:12];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];

    always_comb begin
        alu_op    = ALU_PASS_B;
        imm       = {{20{instr[31]}}, instr[31:20]};
        use_imm   = 1'b0;
        reg_write = 1'b0;
        mem_read  = 1'b0;
        mem_write = 1'b0;
        branch    = 1'b0;
        jal       = 1'b0;
        halt      = 1'b0;
        illegal   = 1'b0;
        case (opcode)
            OP_REG: begin
                reg_write = 1'b1;
                case ({instr[31:25], funct3})
                    {7'h00, 3'd0}: alu_op = ALU_ADD;
                    {7'h20, 3'd0}: alu_op = ALU_SUB;
                    {7'h00, 3'd2}: alu_op = ALU_SLT;
                    {7'h00, 3'd4}: alu_op = ALU_XOR;
                    {7'h00, 3'd6}: alu_op = ALU_OR;
                    {7'h00, 3'd7}: alu_op = ALU_AND;
                    default:       illegal = 1'b1;
                endcase
            end
            OP_IMM, OP_LOAD, OP_STORE: begin
                alu_op    = ALU_ADD;
                use_imm   = 1'b1;
                reg_write = (opcode != OP_STORE);
                mem_read  = (opcode == OP_LOAD);
                mem_write = (opcode == OP_STORE);
                // ADDI is funct3 0, LW and SW are funct3 2
                illegal   = (opcode == OP_IMM) ? (funct3 != 3'd0) : (funct3 != 3'd2);
                if (opcode == OP_STORE) begin
                    imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
                end
            end
            OP_BRANCH: begin
                branch  = 1'b1;
                illegal = (funct3[2:1] != 2'b00);
                imm     = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
            end
            OP_JAL: begin
                jal       = 1'b1;
                reg_write = 1'b1;
                imm       = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
            end
            OP_SYSTEM: begin
                halt    = (instr == EBREAK_INSTR);
                illegal = (instr != EBREAK_INSTR);
            end
            default: illegal = 1'b1;
        endcase
    end

    // x0 is never written and reads as zero
    always_ff @(posedge clk) begin
        if (wb_en && (wb_rd != 5'd0)) begin
            regs[wb_rd] <= wb_data;
        end
    end

    // Same-cycle writeback wins over the stored value
    assign rs1_data = (rs1 == 5'd0) ? '0 :
                      (wb_en && (wb_rd == rs1)) ? wb_data : regs[rs1];
    assign rs2_data = (rs2 == 5'd0) ? '0 :
                      (wb_en && (wb_rd == rs2)) ? wb_data : regs[rs2];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ex_reg_write <= 1'b0;
            ex_mem_read  <= 1'b0;
            ex_mem_write <= 1'b0;
            ex_branch    <= 1'b0;
            ex_jal       <= 1'b0;
            ex_halt      <= 1'b0;
            ex_illegal   <= 1'b0;
        end else begin
            ex_reg_write <= reg_write;
            ex_mem_read  <= mem_read;
            ex_mem_write <= mem_write;
            ex_branch    <= branch;
            ex_jal       <= jal;
            ex_halt      <= halt;
            ex_illegal   <= illegal;
        end
    end

    always_ff @(posedge clk) begin
        ex_pc        <= id_pc;
        ex_rs1_data  <= rs1_data;
        ex_rs2_data  <= rs2_data;
        ex_imm       <= imm;
        ex_rs1       <= rs1;
        ex_rs2       <= rs2;
        ex_rd        <= instr[11:7];
        ex_alu_op    <= alu_op;
        ex_use_imm   <= use_imm;
        ex_branch_ne <= funct3[0];
    end

endmodule

`default_nettype wire

// File: design/execute.sv
// EX and MEM stages of the core, ALU and branches, EX/MEM register, data access and writeback
`timescale 1ns/1ns
`default_nettype none

module execute (
    input  logic                clk,
    input  logic                rst_n,
    input  proc_pkg::word_t     ex_pc, ex_rs1_data, ex_rs2_data, ex_imm,
    input  proc_pkg::reg_idx_t  ex_rd,
    input  proc_pkg::alu_op_e   ex_alu_op,
    input  logic                ex_use_imm, ex_reg_write, ex_mem_read, ex_mem_write,
    input  logic                ex_branch, ex_branch_ne, ex_jal, ex_halt, ex_illegal,
    input  logic                fwd_a, fwd_b,
    input  proc_pkg::word_t     dm_rdata,
    output logic                redirect,
    output proc_pkg::word_t     redirect_pc,
    output logic                dm_req, dm_we,
    output proc_pkg::mem_addr_t dm_addr,
    output proc_pkg::word_t     dm_wdata,
    output logic                wb_en,
    output proc_pkg::reg_idx_t  wb_rd,
    output proc_pkg::word_t     wb_data,
    output logic                halted, err
);
    import proc_pkg::*;

    word_t op_a, rs2_val, op_b, alu_out, m_result;
    logic  commit, m_load, m_store;

    // Only the MEM stage is forwarded, older results come through the register file
    assign op_a    = fwd_a ? wb_data : ex_rs1_data;
    assign rs2_val = fwd_b ? wb_data : ex_rs2_data;
    assign op_b    = ex_use_imm ? ex_imm : rs2_val;

    always_comb begin
        case (ex_alu_op)
            ALU_ADD: alu_out = op_a + op_b;
            ALU_SUB: alu_out = op_a - op_b;
            ALU_AND: alu_out = op_a & op_b;
            ALU_OR:  alu_out = op_a | op_b;
            ALU_XOR: alu_out = op_a ^ op_b;
            ALU_SLT: alu_out = word_t'($signed(op_a) < $signed(op_b));
            default: alu_out = op_b;
        endcase
    end

    // Nothing younger than a halt or an illegal word may take effect
    assign commit      = !halted && !ex_illegal;
    assign redirect    = commit && (ex_jal || (ex_branch && ((op_a == rs2_val) != ex_branch_ne)));
    assign redirect_pc = ex_pc + ex_imm;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb_en   <= 1'b0;
            m_load  <= 1'b0;
            m_store <= 1'b0;
        end else begin
            wb_en   <= commit && ex_reg_write;
            m_load  <= commit && ex_mem_read;
            m_store <= commit && ex_mem_write;
        end
    end

    always_ff @(posedge clk) begin
        wb_rd    <= ex_rd;
        m_result <= ex_jal ? ex_pc + 32'd4 : alu_out;
        dm_wdata <= rs2_val;
    end

    // Sticky until reset
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            halted <= 1'b0;
            err    <= 1'b0;
        end else if (!halted) begin
            halted <= ex_halt || ex_illegal;
            err    <= ex_illegal;
        end
    end

    assign dm_req  = m_load || m_store;
    assign dm_we   = m_store;
    assign dm_addr = mem_addr_t'(m_result >> 2);
    assign wb_data = m_load ? dm_rdata : m_result;

endmodule

`default_nettype wire

// File: design/fetch.sv
// IF stage of the core, holds the PC, requests instruction words and fills the IF/ID register
`timescale 1ns/1ns
`default_nettype none

module fetch (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                run,
    input  logic                halted,
    input  logic                fetch_stall,
    input  logic                flush,
    input  logic                redirect,
    input  proc_pkg::word_t     redirect_pc,
    input  logic                if_gnt,
    input  proc_pkg::word_t     if_rdata,
    output logic                if_req,
    output proc_pkg::mem_addr_t if_addr,
    output proc_pkg::word_t     id_pc,
    output proc_pkg::word_t     id_instr
);
    import proc_pkg::*;

    word_t pc;

    assign if_req  = run && !halted;
    assign if_addr = mem_addr_t'(pc >> 2);

    // PC only moves on a granted fetch or a taken redirect
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc <= RESET_PC;
        end else if (redirect) begin
            pc <= redirect_pc;
        end else if (if_req && if_gnt) begin
            pc <= pc + 32'd4;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            id_instr <= NOP_INSTR;
        end else if (flush || halted || fetch_stall || !if_req) begin
            id_instr <= NOP_INSTR;
        end else begin
            id_instr <= if_rdata;
        end
    end

    always_ff @(posedge clk) begin
        id_pc <= pc;
    end

endmodule

`default_nettype wire

// File: design/hazard_unit.sv
// Hazard control of the core, MEM-to-EX forwarding selects, fetch stall and pipeline flush
`timescale 1ns/1ns
`default_nettype none

module hazard_unit (
    input  proc_pkg::reg_idx_t ex_rs1,
    input  proc_pkg::reg_idx_t ex_rs2,
    input  proc_pkg::reg_idx_t wb_rd,
    input  logic               wb_en,
    input  logic               if_req,
    input  logic               if_gnt,
    input  logic               redirect,
    input  logic               halted,
    output logic               fwd_a,
    output logic               fwd_b,
    output logic               fetch_stall,
    output logic               flush
);

    logic wb_live;

    // Writes to x0 are never forwarded
    assign wb_live = wb_en && (wb_rd != 5'd0);
    assign fwd_a   = wb_live && (wb_rd == ex_rs1);
    assign fwd_b   = wb_live && (wb_rd == ex_rs2);

    // Lost arbitration turns the fetch slot into a bubble
    assign fetch_stall = if_req && !if_gnt;
    assign flush       = redirect || halted;

endmodule

`default_nettype wire

// File: design/mem_arbiter.sv
// Fixed-priority access to the unified memory for the loader, data and fetch ports
`timescale 1ns/1ns
`default_nettype none

module mem_arbiter (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                ext_req, ext_we,
    input  proc_pkg::mem_addr_t ext_addr,
    input  proc_pkg::word_t     ext_wdata,
    input  logic                dm_req, dm_we,
    input  proc_pkg::mem_addr_t dm_addr,
    input  proc_pkg::word_t     dm_wdata,
    input  logic                if_req,
    input  proc_pkg::mem_addr_t if_addr,
    input  proc_pkg::word_t     mem_rdata,
    output logic                if_gnt,
    output proc_pkg::word_t     if_rdata, dm_rdata, ext_rdata,
    output logic                mem_we,
    output proc_pkg::mem_addr_t mem_addr,
    output proc_pkg::word_t     mem_wdata
);

    // Loader, then data, then fetch; decided fresh every cycle
    assign if_gnt = if_req && !ext_req && !dm_req;

    always_comb begin
        if (ext_req) begin
            mem_we    = ext_we;
            mem_addr  = ext_addr;
            mem_wdata = ext_wdata;
        end else if (dm_req) begin
            mem_we    = dm_we;
            mem_addr  = dm_addr;
            mem_wdata = dm_wdata;
        end else begin
            mem_we    = 1'b0;
            mem_addr  = if_addr;
            mem_wdata = '0;
        end
    end

    assign if_rdata = mem_rdata;
    assign dm_rdata = mem_rdata;

    // Loader reads come back one cycle later
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ext_rdata <= '0;
        end else if (ext_req && !ext_we) begin
            ext_rdata <= mem_rdata;
        end
    end

endmodule

`default_nettype wire

// File: design/proc.sv
// Top level of the four-stage RV32I subset core with its shared memory and loader port
`timescale 1ns/1ns
`default_nettype none

module proc (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                run,
    input  logic                ext_req,
    input  logic                ext_we,
    input  proc_pkg::mem_addr_t ext_addr,
    input  proc_pkg::word_t     ext_wdata,
    output proc_pkg::word_t     ext_rdata,
    output logic                halted,
    output logic                err
);
    import proc_pkg::*;

    // Fetch port and IF/ID
    logic      if_req, if_gnt;
    mem_addr_t if_addr;
    word_t     if_rdata, id_pc, id_instr;

    // ID/EX
    word_t    ex_pc, ex_rs1_data, ex_rs2_data, ex_imm;
    reg_idx_t ex_rs1, ex_rs2, ex_rd;
    alu_op_e  ex_alu_op;
    logic     ex_use_imm, ex_reg_write, ex_mem_read, ex_mem_write;
    logic     ex_branch, ex_branch_ne, ex_jal, ex_halt, ex_illegal;

    // Redirect, data port and writeback
    logic      redirect, dm_req, dm_we, wb_en;
    word_t     redirect_pc, dm_wdata, dm_rdata, wb_data;
    mem_addr_t dm_addr;
    reg_idx_t  wb_rd;

    logic fwd_a, fwd_b, fetch_stall, flush;

    // Memory side of the arbiter
    logic      mem_we;
    mem_addr_t mem_addr;
    word_t     mem_wdata, mem_rdata;

    fetch          i_fetch       (.*);
    decode         i_decode      (.*);
    execute        i_execute     (.*);
    hazard_unit    i_hazard_unit (.*);
    mem_arbiter    i_mem_arbiter (.*);
    unified_memory i_memory      (.*);

endmodule

`default_nettype wire

// File: design/proc_pkg.sv
// Shared widths, memory size and instruction encodings of the core, imported by every design file
`default_nettype none

package proc_pkg;

    localparam int XLEN      = 32;
    localparam int MEM_WORDS = 1024;

    typedef logic [XLEN-1:0]              word_t;
    typedef logic [4:0]                   reg_idx_t;
    typedef logic [$clog2(MEM_WORDS)-1:0] mem_addr_t;

    // Byte address of the first fetch after reset
    localparam word_t RESET_PC = 32'h0000_0000;

    // ADDI x0,x0,0 fills empty pipeline slots
    localparam word_t NOP_INSTR    = 32'h0000_0013;
    localparam word_t EBREAK_INSTR = 32'h0010_0073;

    typedef enum logic [6:0] {
        OP_REG    = 7'b0110011,
        OP_IMM    = 7'b0010011,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_BRANCH = 7'b1100011,
        OP_JAL    = 7'b1101111,
        OP_SYSTEM = 7'b1110011
    } opcode_e;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_PASS_B
    } alu_op_e;

endpackage

`default_nettype wire

// File: design/unified_memory.sv
// Word-addressed instruction and data memory with combinational read and clocked write
`timescale 1ns/1ns
`default_nettype none

module unified_memory (
    input  logic                clk,
    input  logic                mem_we,
    input  proc_pkg::mem_addr_t mem_addr,
    input  proc_pkg::word_t     mem_wdata,
    output proc_pkg::word_t     mem_rdata
);
    import proc_pkg::*;

    word_t words [MEM_WORDS];

    assign mem_rdata = words[mem_addr];

    always_ff @(posedge clk) begin
        if (mem_we) begin
            words[mem_addr] <= mem_wdata;
        end
    end

endmodule

`default_nettype wire

// File: proc.f
design/proc_pkg.sv
design/fetch.sv
design/decode.sv
design/execute.sv
design/hazard_unit.sv
design/mem_arbiter.sv
design/unified_memory.sv
design/proc.sv
test/tb_proc.sv

// File: test/tb_proc.sv
// Directed testbench that loads programs into the core through the loader port and checks stored results
`timescale 1ns/1ns
`default_nettype none

module tb_proc;
    import proc_pkg::*;

    logic      clk;
    logic      rst_n;
    logic      run;
    logic      ext_req;
    logic      ext_we;
    mem_addr_t ext_addr;
    word_t     ext_wdata;
    word_t     ext_rdata;
    logic      halted;
    logic      err;

    int    errors;
    int    checks;
    word_t rng_state;
    word_t prog [$];
    word_t expect_q [$];

    proc i_proc (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic word_t next_random();
        rng_state ^= rng_state << 13;
        rng_state ^= rng_state >> 17;
        rng_state ^= rng_state << 5;
        return rng_state;
    endfunction

    function automatic logic [11:0] rand_imm();
        word_t v;
        v = next_random();
        return v[11:0];
    endfunction

    function automatic word_t sext12(input logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    // Result area marker words depend on the full word address
    function automatic word_t sentinel(input mem_addr_t addr);
        return {16'h5EED, 6'd0, addr};
    endfunction

    function automatic word_t r_type(input logic [6:0] f7, input logic [2:0] f3,
                                     input reg_idx_t rd, input reg_idx_t rs1,
                                     input reg_idx_t rs2);
        return {f7, rs2, rs1, f3, rd, OP_REG};
    endfunction

    function automatic word_t i_type(input opcode_e op, input logic [2:0] f3,
                                     input reg_idx_t rd, input reg_idx_t rs1,
                                     input logic [11:0] imm);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic word_t addi(input reg_idx_t rd, input reg_idx_t rs1,
                                   input logic [11:0] imm);
        return i_type(OP_IMM, 3'd0, rd, rs1, imm);
    endfunction

    function automatic word_t lw(input reg_idx_t rd, input reg_idx_t rs1,
                                 input logic [11:0] imm);
        return i_type(OP_LOAD, 3'd2, rd, rs1, imm);
    endfunction

    function automatic word_t sw(input reg_idx_t rs2, input reg_idx_t rs1,
                                 input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'd2, imm[4:0], OP_STORE};
    endfunction

    // funct3 0 is BEQ, 1 is BNE
    function automatic word_t b_type(input logic [2:0] f3, input reg_idx_t rs1,
                                     input reg_idx_t rs2, input logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OP_BRANCH};
    endfunction

    function automatic word_t j_type(input reg_idx_t rd, input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, OP_JAL};
    endfunction

    function automatic word_t ebreak();
        return i_type(OP_SYSTEM, 3'd0, 5'd0, 5'd0, 12'd1);
    endfunction

    task automatic check_word(input proc_pkg::word_t got, input proc_pkg::word_t exp,
                              input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t ns: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic finish_run();
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    endtask

    task automatic apply_reset();
        @(posedge clk);
        rst_n   <= 1'b0;
        run     <= 1'b0;
        ext_req <= 1'b0;
        ext_we  <= 1'b0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
    endtask

    task automatic write_word(input mem_addr_t addr, input word_t data);
        @(posedge clk);
        ext_req   <= 1'b1;
        ext_we    <= 1'b1;
        ext_addr  <= addr;
        ext_wdata <= data;
        @(posedge clk);
        ext_req <= 1'b0;
        ext_we  <= 1'b0;
    endtask

    // Read data is registered, so it is taken half a cycle after the capturing edge
    task automatic read_word(input mem_addr_t addr, output word_t data);
        @(posedge clk);
        ext_req  <= 1'b1;
        ext_we   <= 1'b0;
        ext_addr <= addr;
        @(posedge clk);
        ext_req <= 1'b0;
        @(negedge clk);
        data = ext_rdata;
    endtask

    task automatic load_program();
        foreach (prog[i]) begin
            write_word(i, prog[i]);
        end
    endtask

    // Result area starts at word 256, byte 1024
    task automatic fill_sentinels(input int count);
        for (int i = 0; i < count; i++) begin
            write_word(256 + i, sentinel(256 + i));
        end
    endtask

    task automatic run_until_halt(input string name);
        int cycles;
        cycles = 0;
        @(posedge clk);
        run <= 1'b1;
        @(negedge clk);
        while (!halted && cycles < 2000) begin
            @(negedge clk);
            cycles++;
        end
        if (!halted) begin
            $display("Timeout: %s did not halt within 2000 cycles", name);
            errors++;
            finish_run();
        end else begin
            @(posedge clk);
            run <= 1'b0;
        end
    endtask

    task automatic check_results(input string name);
        word_t got;
        foreach (expect_q[i]) begin
            read_word(256 + i, got);
            check_word(got, expect_q[i], $sformatf("%s result %0d", name, i));
        end
        check_flag(halted, 1'b1, {name, " halted"});
    endtask

    task automatic test_alu_chain();
        word_t       a, b;
        word_t       r [7];
        logic [11:0] ia, ib, ic, id;
        int          ka, kb;
        for (int round = 0; round < 3; round++) begin
            ia = rand_imm();
            ib = rand_imm();
            ic = rand_imm();
            id = rand_imm();
            ka = next_random() % 20;
            kb = next_random() % 20;
            a  = (sext12(ia) << ka) + sext12(ib);
            b  = (sext12(ic) << kb) + sext12(id);
            prog.delete();
            expect_q.delete();
            prog.push_back(addi(10, 0, 12'd1024));
            // Doubling through ADD builds wide operands without shifts
            prog.push_back(addi(1, 0, ia));
            repeat (ka) prog.push_back(r_type(7'h00, 3'd0, 1, 1, 1));
            prog.push_back(addi(1, 1, ib));
            prog.push_back(addi(2, 0, ic));
            repeat (kb) prog.push_back(r_type(7'h00, 3'd0, 2, 2, 2));
            prog.push_back(addi(2, 2, id));
            prog.push_back(r_type(7'h00, 3'd0, 3, 1, 2));
            prog.push_back(r_type(7'h20, 3'd0, 4, 3, 1));
            prog.push_back(r_type(7'h00, 3'd7, 5, 4, 1));
            prog.push_back(r_type(7'h00, 3'd6, 6, 5, 3));
            prog.push_back(r_type(7'h00, 3'd4, 7, 6, 4));
            prog.push_back(r_type(7'h00, 3'd2, 8, 7, 5));
            prog.push_back(r_type(7'h00, 3'd2, 9, 1, 2));
            r[0] = a + b;
            r[1] = r[0] - a;
            r[2] = r[1] & a;
            r[3] = r[2] | r[0];
            r[4] = r[3] ^ r[1];
            r[5] = ($signed(r[4]) < $signed(r[2])) ? 32'd1 : 32'd0;
            r[6] = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            // Newest result is stored first so store data is forwarded
            for (int i = 6; i >= 0; i--) begin
                prog.push_back(sw(3 + i, 10, 4 * i));
            end
            for (int i = 0; i < 7; i++) begin
                expect_q.push_back(r[i]);
            end
            prog.push_back(ebreak());
            apply_reset();
            load_program();
            run_until_halt("alu chain");
            check_results("alu chain");
            check_flag(err, 1'b0, "alu chain err");
        end
    endtask

    task automatic test_load_store();
        word_t d0, d1;
        d0 = next_random();
        d1 = next_random();
        prog = '{addi(10, 0, 12'd1024), addi(11, 0, 12'd1200), lw(1, 11, 0),
                 r_type(7'h00, 3'd0, 2, 1, 1), lw(3, 11, 4), r_type(7'h20, 3'd0, 4, 3, 1),
                 sw(2, 10, 0), sw(4, 10, 4), lw(5, 10, 0), r_type(7'h00, 3'd4, 6, 5, 3),
                 sw(6, 10, 8), sw(3, 10, 12), lw(7, 10, 12), r_type(7'h00, 3'd0, 8, 7, 7),
                 sw(8, 10, 16), ebreak()};
        expect_q = '{d0 + d0, d1 - d0, (d0 + d0) ^ d1, d1, d1 + d1};
        apply_reset();
        load_program();
        // Operands at byte 1200, word 300
        write_word(300, d0);
        write_word(301, d1);
        run_until_halt("load/store");
        check_results("load/store");
        check_flag(err, 1'b0, "load/store err");
    endtask

    task automatic test_control_flow();
        prog = '{addi(10, 0, 12'd1024), addi(1, 0, 5), addi(2, 0, 5), addi(3, 0, 7),
                 b_type(3'd0, 1, 2, 8), sw(1, 10, 0), sw(2, 10, 4),
                 b_type(3'd1, 1, 2, 8), sw(3, 10, 8),
                 b_type(3'd0, 1, 3, 8), sw(1, 10, 12),
                 b_type(3'd1, 1, 3, 8), sw(3, 10, 16),
                 j_type(5, 12), sw(1, 10, 20), sw(1, 10, 24), sw(5, 10, 28), ebreak()};
        // JAL sits at byte 52, so the link is 56
        expect_q = '{sentinel(256), 32'd5, 32'd7, 32'd5, sentinel(260), sentinel(261),
                     sentinel(262), 32'd56};
        apply_reset();
        load_program();
        fill_sentinels(8);
        run_until_halt("control flow");
        check_results("control flow");
        check_flag(err, 1'b0, "control flow err");
    endtask

    task automatic test_illegal();
        // Opcode 7'h7F is outside the subset
        prog = '{addi(10, 0, 12'd1024), addi(1, 0, 99), 32'h0000_007F, sw(1, 10, 0), ebreak()};
        expect_q = '{sentinel(256)};
        apply_reset();
        load_program();
        fill_sentinels(1);
        run_until_halt("illegal");
        check_results("illegal");
        check_flag(err, 1'b1, "illegal err");
        apply_reset();
        @(negedge clk);
        check_flag(err, 1'b0, "err after reset");
        check_flag(halted, 1'b0, "halted after reset");
    endtask

    task automatic test_loader();
        mem_addr_t la [8];
        word_t     ld [8];
        word_t     got;
        apply_reset();
        for (int i = 0; i < 8; i++) begin
            la[i] = 512 + i * 64 + (next_random() % 64);
            ld[i] = next_random();
            write_word(la[i], ld[i]);
        end
        for (int i = 0; i < 8; i++) begin
            read_word(la[i], got);
            check_word(got, ld[i], $sformatf("loader word at %0d", la[i]));
        end
        prog = '{addi(10, 0, 12'd1024), addi(0, 0, 123), sw(0, 10, 0), addi(0, 10, 77),
                 r_type(7'h00, 3'd0, 2, 0, 0), sw(2, 10, 4), ebreak()};
        expect_q = '{32'd0, 32'd0};
        load_program();
        fill_sentinels(2);
        run_until_halt("x0 writes");
        check_results("x0 writes");
        check_flag(err, 1'b0, "x0 writes err");
    endtask

    initial begin
        rst_n     = 1'b0;
        run       = 1'b0;
        ext_req   = 1'b0;
        ext_we    = 1'b0;
        ext_addr  = '0;
        ext_wdata = '0;
        errors    = 0;
        checks    = 0;
        rng_state = 32'd21921;
        test_alu_chain();
        test_load_store();
        test_control_flow();
        test_illegal();
        test_loader();
        finish_run();
    end

endmodule

`default_nettype wire
